// ==== run.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator; status follows the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_rv_core -o tb_rv_core

./obj_dir/tb_rv_core | tee sim.log

grep -qx "Testbench passed" sim.log

// ==== src.f ====
+incdir+src
src/rv_core_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_hazard_unit.sv
src/rv_execute.sv
src/rv_mem_stage.sv
src/rv_core.sv
testbench/tb_dmem_model.sv
testbench/tb_rv_core.sv

// ==== src/rv_core.sv ====
// 4-stage RV64 integer pipe; the instruction source must hold instr_i while valid is high and ready low
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_config.svh"

module rv_core (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    input  wire logic                instr_valid_i,
    input  wire rv_core_pkg::instr_t instr_i,
    output logic                     instr_ready_o,
    output logic                     dmem_req_o,
    output rv_core_pkg::word_t       dmem_addr_o,
    input  wire logic                dmem_ready_i,
    input  wire rv_core_pkg::word_t  dmem_rdata_i,
    output logic                     commit_valid_o,
    output rv_core_pkg::commit_t     commit_o
);
    import rv_core_pkg::*;

    word_t    pc_q;
    logic     id_valid_q;
    word_t    id_pc_q;
    instr_t   id_instr_q;
    reg_idx_t id_rs1, id_rs2, id_rd;
    word_t    id_imm;
    ctrl_t    id_ctrl;
    word_t    rf_data1, rf_data2;
    word_t    opa, opb;
    logic     load_use, mem_busy, id_hold, accept;
    stage_t   ex_stage, m_stage;
    word_t    m_result;
    stage_t   wb_d, wb_data_q, wb_stage;
    logic     wb_valid_q;
    logic     commit_valid_q;
    commit_t  commit_q;

    //////////////////////////////
    // intake and id/ex
    assign id_hold       = load_use || mem_busy;
    assign instr_ready_o = !id_hold;
    assign accept        = instr_valid_i && instr_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q       <= `RV_RESET_PC;
            id_valid_q <= 1'b0;
        end else begin
            if (!id_hold) begin
                id_valid_q <= instr_valid_i;
            end
            if (accept) begin
                pc_q <= pc_q + word_t'(4);      // one slot per accepted instr
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!id_hold) begin
            id_pc_q    <= pc_q;
            id_instr_q <= instr_i;
        end
    end

    rv_decode i_rv_decode (
        .instr_i (id_instr_q),
        .rs1_o   (id_rs1),
        .rs2_o   (id_rs2),
        .rd_o    (id_rd),
        .imm_o   (id_imm),
        .ctrl_o  (id_ctrl)
    );

    rv_regfile i_rv_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .rs1_i    (id_rs1),
        .rs2_i    (id_rs2),
        .rdata1_o (rf_data1),
        .rdata2_o (rf_data2),
        .we_i     (wb_stage.valid && wb_stage.ctrl.reg_we),
        .waddr_i  (wb_stage.rd),
        .wdata_i  (wb_stage.result)
    );

    rv_hazard_unit i_rv_hazard_unit (
        .id_valid_i (id_valid_q),
        .id_ctrl_i  (id_ctrl),
        .rs1_i      (id_rs1),
        .rs2_i      (id_rs2),
        .rf_data1_i (rf_data1),
        .rf_data2_i (rf_data2),
        .ex_stage_i (ex_stage),
        .m_stage_i  (m_stage),
        .wb_stage_i (wb_stage),
        .m_result_i (m_result),
        .opa_o      (opa),
        .opb_o      (opb),
        .load_use_o (load_use)
    );

    //////////////////////////////
    // ex and m
    rv_execute i_rv_execute (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .hold_i     (mem_busy),
        .id_valid_i (id_valid_q && !load_use),  // bubble while waiting on the load
        .id_pc_i    (id_pc_q),
        .id_instr_i (id_instr_q),
        .id_ctrl_i  (id_ctrl),
        .id_rd_i    (id_rd),
        .opa_i      (opa),
        .opb_i      (opb),
        .imm_i      (id_imm),
        .ex_stage_o (ex_stage)
    );

    rv_mem_stage i_rv_mem_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ex_stage_i   (ex_stage),
        .dmem_req_o   (dmem_req_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_ready_i (dmem_ready_i),
        .dmem_rdata_i (dmem_rdata_i),
        .m_stage_o    (m_stage),
        .m_result_o   (m_result),
        .mem_busy_o   (mem_busy)
    );

    //////////////////////////////
    // wb and commit
    always_comb begin
        wb_d        = m_stage;
        wb_d.valid  = m_stage.valid && !mem_busy;   // bubble while m waits
        wb_d.result = m_result;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_q     <= 1'b0;
            commit_valid_q <= 1'b0;
        end else begin
            wb_valid_q     <= wb_d.valid;
            commit_valid_q <= wb_stage.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_data_q <= wb_d;
        if (wb_stage.valid) begin
            commit_q <= '{pc:     wb_stage.pc,
                          instr:  wb_stage.instr,
                          rd:     wb_stage.rd,
                          reg_we: wb_stage.ctrl.reg_we,
                          wdata:  wb_stage.result};
        end
    end

    always_comb begin
        wb_stage       = wb_data_q;
        wb_stage.valid = wb_valid_q;
    end

    assign commit_valid_o = commit_valid_q;
    assign commit_o       = commit_q;

endmodule

`default_nettype wire

// ==== src/rv_core_config.svh ====
// build-time constants for the core; XLEN is fixed at 64 and the register count must be a power of two
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// datapath
`define RV_XLEN      64
`define RV_REG_NUM   32       // x0..x31

// pc of the first accepted instruction
`define RV_RESET_PC  64'h8000_0000

// watchdog budget in cycles per instruction sent
// long data-port waits eat into it
`define RV_TIMEOUT_PER_INSTR 20

`endif

// ==== src/rv_core_pkg.sv ====
// shared core types; widths come from rv_core_config.svh, which must be on the include path
`default_nettype none
`include "rv_core_config.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]            word_t;     // one register value
    typedef logic [31:0]                    instr_t;
    typedef logic [$clog2(`RV_REG_NUM)-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL
    } alu_op_e;

    typedef enum logic {
        MEM_IDLE,
        MEM_WAIT        // request out, waiting for ready
    } mem_state_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;     // operand b from immediate
        logic    is_load;
        logic    reg_we;      // already cleared for x0
        logic    rs1_used;
        logic    rs2_used;
    } ctrl_t;

    typedef struct packed {
        word_t    pc;
        instr_t   instr;
        reg_idx_t rd;
        logic     reg_we;
        word_t    wdata;
    } commit_t;

    // what moves from one stage to the next
    typedef struct packed {
        logic     valid;
        word_t    pc;
        instr_t   instr;
        ctrl_t    ctrl;
        reg_idx_t rd;
        word_t    result;     // alu result, load address in ex/m
    } stage_t;

endpackage

`default_nettype wire

// ==== src/rv_decode.sv ====
// decodes ADDI, SLLI, ADD, SUB, AND, OR, XOR and LD only; anything else becomes a no-write bubble
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
    input  wire rv_core_pkg::instr_t   instr_i,
    output rv_core_pkg::reg_idx_t      rs1_o,
    output rv_core_pkg::reg_idx_t      rs2_o,
    output rv_core_pkg::reg_idx_t      rd_o,
    output rv_core_pkg::word_t         imm_o,
    output rv_core_pkg::ctrl_t         ctrl_o
);
    import rv_core_pkg::*;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       known;
    ctrl_t      ctrl;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rd_o   = instr_i[11:7];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];
    assign imm_o  = {{($bits(word_t)-12){instr_i[31]}}, instr_i[31:20]};  // i-type only

    always_comb begin
        ctrl  = '0;
        known = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                ctrl.use_imm  = 1'b1;
                ctrl.rs1_used = 1'b1;
                if (funct3 == 3'b000) begin
                    ctrl.alu_op = ALU_ADD;
                    known       = 1'b1;
                end else if (funct3 == 3'b001 && funct7[6:1] == 6'b0) begin
                    ctrl.alu_op = ALU_SLL;          // shamt is imm[5:0]
                    known       = 1'b1;
                end
            end
            OPC_OP: begin
                ctrl.rs1_used = 1'b1;
                ctrl.rs2_used = 1'b1;
                known         = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: ctrl.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: ctrl.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: ctrl.alu_op = ALU_XOR;
                    default:              known       = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                if (funct3 == 3'b011) begin     // ld, address = rs1 + imm
                    ctrl.alu_op   = ALU_ADD;
                    ctrl.use_imm  = 1'b1;
                    ctrl.is_load  = 1'b1;
                    ctrl.rs1_used = 1'b1;
                    known         = 1'b1;
                end
            end
            default: known = 1'b0;
        endcase
        if (!known) begin
            ctrl = '0;                          // bubble, no sources, no write
        end else begin
            ctrl.reg_we = (rd_o != '0);
        end
    end

    assign ctrl_o = ctrl;

endmodule

`default_nettype wire

// ==== src/rv_execute.sv ====
// single-cycle ALU; SLL uses the low 6 bits of operand b, hold_i freezes the whole EX register
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire logic                  hold_i,
    input  wire logic                  id_valid_i,
    input  wire rv_core_pkg::word_t    id_pc_i,
    input  wire rv_core_pkg::instr_t   id_instr_i,
    input  wire rv_core_pkg::ctrl_t    id_ctrl_i,
    input  wire rv_core_pkg::reg_idx_t id_rd_i,
    input  wire rv_core_pkg::word_t    opa_i,
    input  wire rv_core_pkg::word_t    opb_i,
    input  wire rv_core_pkg::word_t    imm_i,
    output rv_core_pkg::stage_t        ex_stage_o
);
    import rv_core_pkg::*;

    word_t  opb_sel;
    word_t  alu_res;
    stage_t ex_d;
    stage_t ex_data_q;
    logic   ex_valid_q;

    assign opb_sel = id_ctrl_i.use_imm ? imm_i : opb_i;

    always_comb begin
        case (id_ctrl_i.alu_op)
            ALU_ADD: alu_res = opa_i + opb_sel;
            ALU_SUB: alu_res = opa_i - opb_sel;
            ALU_AND: alu_res = opa_i & opb_sel;
            ALU_OR:  alu_res = opa_i | opb_sel;
            ALU_XOR: alu_res = opa_i ^ opb_sel;
            ALU_SLL: alu_res = opa_i << opb_sel[5:0];
            default: alu_res = opa_i + opb_sel;
        endcase
    end

    always_comb begin
        ex_d.valid  = id_valid_i;               // low on bubble
        ex_d.pc     = id_pc_i;
        ex_d.instr  = id_instr_i;
        ex_d.ctrl   = id_ctrl_i;
        ex_d.rd     = id_rd_i;
        ex_d.result = alu_res;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_q <= 1'b0;
        end else if (!hold_i) begin
            ex_valid_q <= ex_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            ex_data_q <= ex_d;
        end
    end

    always_comb begin
        ex_stage_o       = ex_data_q;
        ex_stage_o.valid = ex_valid_q;
    end

endmodule

`default_nettype wire

// ==== src/rv_hazard_unit.sv ====
// purely combinational; stage inputs must carry cleared valids for bubbles, EX load data is never forwarded
`timescale 1ns/10ps
`default_nettype none

module rv_hazard_unit (
    input  wire logic                  id_valid_i,
    input  wire rv_core_pkg::ctrl_t    id_ctrl_i,
    input  wire rv_core_pkg::reg_idx_t rs1_i,
    input  wire rv_core_pkg::reg_idx_t rs2_i,
    input  wire rv_core_pkg::word_t    rf_data1_i,
    input  wire rv_core_pkg::word_t    rf_data2_i,
    input  wire rv_core_pkg::stage_t   ex_stage_i,
    input  wire rv_core_pkg::stage_t   m_stage_i,
    input  wire rv_core_pkg::stage_t   wb_stage_i,
    input  wire rv_core_pkg::word_t    m_result_i,
    output rv_core_pkg::word_t         opa_o,
    output rv_core_pkg::word_t         opb_o,
    output logic                       load_use_o
);
    import rv_core_pkg::*;

    logic ex_wr;
    logic m_wr;
    logic wb_wr;

    assign ex_wr = ex_stage_i.valid && ex_stage_i.ctrl.reg_we;
    assign m_wr  = m_stage_i.valid && m_stage_i.ctrl.reg_we;
    assign wb_wr = wb_stage_i.valid && wb_stage_i.ctrl.reg_we;

    // youngest writer wins: ex, then m, then wb
    function automatic word_t fwd_sel(input reg_idx_t rs, input logic used, input word_t rf_data);
        word_t sel;
        sel = rf_data;
        if (used && rs != '0) begin
            if (ex_wr && rs == ex_stage_i.rd) begin
                if (!ex_stage_i.ctrl.is_load) begin
                    sel = ex_stage_i.result;
                end                             // load: stall below, retried next cycle
            end else if (m_wr && rs == m_stage_i.rd) begin
                sel = m_result_i;               // alu result or read data
            end else if (wb_wr && rs == wb_stage_i.rd) begin
                sel = wb_stage_i.result;
            end
        end
        return sel;
    endfunction

    always_comb begin
        opa_o = fwd_sel(rs1_i, id_ctrl_i.rs1_used, rf_data1_i);
        opb_o = fwd_sel(rs2_i, id_ctrl_i.rs2_used, rf_data2_i);
    end

    //////////////////////////////
    // load-use
    assign load_use_o = id_valid_i && ex_wr && ex_stage_i.ctrl.is_load &&
                        ((id_ctrl_i.rs1_used && rs1_i == ex_stage_i.rd) ||
                         (id_ctrl_i.rs2_used && rs2_i == ex_stage_i.rd));

    // the load in ex got its reg_we from decode, which drops it for x0
    always_comb begin
        if (load_use_o) begin
            a_no_x0_load_use: assert (ex_stage_i.rd != '0)
                else $error("load-use stall on x0");
        end
    end

endmodule

`default_nettype wire

// ==== src/rv_mem_stage.sv ====
// one load outstanding at a time; the responder must only raise dmem_ready_i while dmem_req_o is high
`timescale 1ns/10ps
`default_nettype none

module rv_mem_stage (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    input  wire rv_core_pkg::stage_t ex_stage_i,
    output logic                     dmem_req_o,
    output rv_core_pkg::word_t       dmem_addr_o,
    input  wire logic                dmem_ready_i,
    input  wire rv_core_pkg::word_t  dmem_rdata_i,
    output rv_core_pkg::stage_t      m_stage_o,
    output rv_core_pkg::word_t       m_result_o,
    output logic                     mem_busy_o
);
    import rv_core_pkg::*;

    mem_state_e state_q;
    mem_state_e state_d;
    stage_t     m_data_q;
    logic       m_valid_q;
    logic       ex_is_load;

    assign ex_is_load  = ex_stage_i.valid && ex_stage_i.ctrl.is_load;
    assign dmem_req_o  = (state_q == MEM_WAIT);
    assign dmem_addr_o = m_data_q.result;       // held while busy
    assign mem_busy_o  = dmem_req_o && !dmem_ready_i;
    assign m_result_o  = m_data_q.ctrl.is_load ? dmem_rdata_i : m_data_q.result;

    //////////////////////////////
    // request fsm
    always_comb begin
        state_d = state_q;
        case (state_q)
            MEM_IDLE: if (ex_is_load) state_d = MEM_WAIT;
            MEM_WAIT: if (dmem_ready_i && !ex_is_load) state_d = MEM_IDLE;  // back to back stays
            default:  state_d = MEM_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= MEM_IDLE;
            m_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (!mem_busy_o) begin
                m_valid_q <= ex_stage_i.valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy_o) begin
            m_data_q <= ex_stage_i;
        end
    end

    always_comb begin
        m_stage_o       = m_data_q;
        m_stage_o.valid = m_valid_q;
    end

    // ready is only meaningful as the answer to a pending request
    a_ready_in_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_ready_i |-> dmem_req_o)
        else $error("dmem ready without a request");

endmodule

`default_nettype wire

// ==== src/rv_regfile.sv ====
// 2R1W register file; reads are combinational and see a write only after its clock edge
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_config.svh"

module rv_regfile (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire rv_core_pkg::reg_idx_t rs1_i,
    input  wire rv_core_pkg::reg_idx_t rs2_i,
    output rv_core_pkg::word_t         rdata1_o,
    output rv_core_pkg::word_t         rdata2_o,
    input  wire logic                  we_i,
    input  wire rv_core_pkg::reg_idx_t waddr_i,
    input  wire rv_core_pkg::word_t    wdata_i
);
    import rv_core_pkg::*;

    word_t regs_q [`RV_REG_NUM];

    assign rdata1_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];   // x0 hardwired
    assign rdata2_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RV_REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // decode clears reg_we for rd x0, so wb must never try it
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        we_i |-> waddr_i != '0)
        else $error("regfile write to x0");

endmodule

`default_nettype wire

// ==== testbench/tb_dmem_model.sv ====
// data-memory responder for one outstanding load; latency 0 to 5 cycles, data is address XOR a fixed pattern
`timescale 1ns/10ps
`default_nettype none

module tb_dmem_model #(
    parameter logic [31:0] SEED = 32'h87e9
) (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               req_i,
    input  wire rv_core_pkg::word_t addr_i,
    output logic                    ready_o,
    output rv_core_pkg::word_t      rdata_o
);
    import rv_core_pkg::*;

    localparam word_t DATA_PATTERN = 64'h5a5a_0000_a5a5_1234;

    logic [2:0] lat_q;      // cycles of ready low for the current request
    logic [2:0] wait_q;
    integer     seed;

    initial seed = SEED;

    // ready only ever rises while the core requests
    assign ready_o = req_i && (wait_q == lat_q);
    assign rdata_o = addr_i ^ DATA_PATTERN;

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lat_q  <= 3'd0;
            wait_q <= 3'd0;
        end else if (req_i && ready_o) begin
            lat_q  <= 3'($unsigned($random(seed)) % 6);    // next request
            wait_q <= 3'd0;
        end else if (req_i) begin
            wait_q <= wait_q + 3'd1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_rv_core.sv ====
// random instruction streams checked commit by commit against an in-order ISA model; at most 512 instructions
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_config.svh"

module tb_rv_core;
    import rv_core_pkg::*;

    localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam word_t      MEM_PATTERN = 64'h5a5a_0000_a5a5_1234;
    localparam int         N_ALU       = 60;
    localparam int         N_LOAD_USE  = 30;    // load plus user pairs
    localparam int         N_X0        = 20;
    localparam int         N_MIX       = 200;
    localparam int         N_TOTAL     = N_ALU + 2 * N_LOAD_USE + N_X0 + N_MIX;
    localparam int         CYCLE_LIMIT = `RV_TIMEOUT_PER_INSTR * N_TOTAL + 100;

    logic     clk;
    logic     rst_n_i;
    logic     instr_valid_i;
    instr_t   instr_i;
    logic     instr_ready_o;
    logic     dmem_req_o;
    word_t    dmem_addr_o;
    logic     dmem_ready_i;
    word_t    dmem_rdata_i;
    logic     commit_valid_o;
    commit_t  commit_o;

    integer   seed = 32'h87e9;
    word_t    ref_regs [`RV_REG_NUM];   // architectural state in program order
    commit_t  exp_mem [512];            // expected commits, indexed by acceptance
    commit_t  exp_cur;
    word_t    model_pc;
    int       wr_idx = 0;
    int       rd_idx = 0;
    int       err_cnt = 0;
    int       cycle_cnt = 0;
    int       n_tests = 0;
    logic     seen_accept = 1'b0;
    reg_idx_t recent [3];               // last destinations, distance 1 to 3

    rv_core i_rv_core (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .dmem_req_o     (dmem_req_o),
        .dmem_addr_o    (dmem_addr_o),
        .dmem_ready_i   (dmem_ready_i),
        .dmem_rdata_i   (dmem_rdata_i),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    tb_dmem_model #(.SEED(32'h87e9)) i_tb_dmem_model (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (dmem_req_o),
        .addr_i  (dmem_addr_o),
        .ready_o (dmem_ready_i),
        .rdata_o (dmem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // reporting
    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        err_cnt++;
        $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        err_cnt++;
        $display("error at %0t: %s", $time, what);
    endtask

    //////////////////////////////
    // reference model
    task automatic model_accept(input instr_t ins);
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        word_t    imm;
        word_t    res;
        logic     we;
        rd  = ins[11:7];
        a   = ref_regs[ins[19:15]];
        b   = ref_regs[ins[24:20]];
        imm = {{52{ins[31]}}, ins[31:20]};
        we  = 1'b1;
        res = '0;
        if (ins[6:0] == OPC_OP_IMM && ins[14:12] == 3'b000) begin
            res = a + imm;                                  // addi
        end else if (ins[6:0] == OPC_OP_IMM && ins[14:12] == 3'b001 && ins[31:26] == 6'b0) begin
            res = a << ins[25:20];                          // slli, 6-bit shamt
        end else if (ins[6:0] == OPC_LOAD && ins[14:12] == 3'b011) begin
            res = (a + imm) ^ MEM_PATTERN;                  // ld from the memory model
        end else if (ins[6:0] == OPC_OP) begin
            case ({ins[31:25], ins[14:12]})
                10'b0000000_000: res = a + b;
                10'b0100000_000: res = a - b;
                10'b0000000_111: res = a & b;
                10'b0000000_110: res = a | b;
                10'b0000000_100: res = a ^ b;
                default:         we  = 1'b0;
            endcase
        end else begin
            we = 1'b0;
        end
        if (rd == '0) begin
            we = 1'b0;
        end
        if (we) begin
            ref_regs[rd] = res;
        end
        exp_mem[wr_idx] <= '{pc: model_pc, instr: ins, rd: rd, reg_we: we, wdata: res};
        wr_idx          <= wr_idx + 1;
        model_pc         = model_pc + 64'd4;
    endtask

    always @(posedge clk) begin
        if (rst_n_i && instr_valid_i && instr_ready_o) begin
            model_accept(instr_i);
            seen_accept <= 1'b1;
        end
        if (rst_n_i && commit_valid_o) begin
            rd_idx <= rd_idx + 1;
        end
    end

    always_comb exp_cur = exp_mem[rd_idx];

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles: %0d of %0d accepted instructions committed",
                     cycle_cnt, rd_idx, wr_idx);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////
    // checks
    a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
        !seen_accept |-> !commit_valid_o && !dmem_req_o)
        else report_failure("commit or data request before the first accepted instruction");

    a_commit_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_o |-> rd_idx < wr_idx)
        else report_failure("commit with no accepted instruction outstanding");

    a_commit_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_o |-> commit_o.pc == exp_cur.pc)
        else report_mismatch("commit_o.pc", $sampled(commit_o.pc), $sampled(exp_cur.pc));

    a_commit_instr: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_o |-> commit_o.instr == exp_cur.instr)
        else report_mismatch("commit_o.instr", word_t'($sampled(commit_o.instr)),
                             word_t'($sampled(exp_cur.instr)));

    a_commit_rd: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_o |-> commit_o.rd == exp_cur.rd)
        else report_mismatch("commit_o.rd", word_t'($sampled(commit_o.rd)),
                             word_t'($sampled(exp_cur.rd)));

    a_commit_we: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_o |-> commit_o.reg_we == exp_cur.reg_we)
        else report_mismatch("commit_o.reg_we", word_t'($sampled(commit_o.reg_we)),
                             word_t'($sampled(exp_cur.reg_we)));

    a_commit_wdata: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_o && exp_cur.reg_we |-> commit_o.wdata == exp_cur.wdata)
        else report_mismatch("commit_o.wdata", $sampled(commit_o.wdata), $sampled(exp_cur.wdata));

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_req_o && !dmem_ready_i |=> $stable(dmem_addr_o))
        else report_failure("dmem_addr_o changed while the request was still waiting");

    //////////////////////////////
    // stimulus
    function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic reg_idx_t pick_dst();
        return reg_idx_t'(1 + $unsigned($random(seed)) % 7);   // x1..x7
    endfunction

    function automatic reg_idx_t pick_src();
        int r;
        r = int'($unsigned($random(seed)) % 4);
        if (r == 3) begin
            return reg_idx_t'($unsigned($random(seed)) % 8);
        end
        return recent[r];
    endfunction

    function automatic instr_t rand_alu(input reg_idx_t rd, input reg_idx_t rs1,
                                        input reg_idx_t rs2);
        logic [11:0] imm;
        int          k;
        imm = 12'($random(seed));
        k   = int'($unsigned($random(seed)) % 7);
        case (k)
            0:       return enc_i(imm, rs1, 3'b000, rd, OPC_OP_IMM);
            1:       return enc_i({6'b0, imm[5:0]}, rs1, 3'b001, rd, OPC_OP_IMM);
            2:       return enc_r(7'h00, rs2, rs1, 3'b000, rd);
            3:       return enc_r(7'h20, rs2, rs1, 3'b000, rd);     // sub
            4:       return enc_r(7'h00, rs2, rs1, 3'b111, rd);
            5:       return enc_r(7'h00, rs2, rs1, 3'b110, rd);
            default: return enc_r(7'h00, rs2, rs1, 3'b100, rd);
        endcase
    endfunction

    // offer one instruction and wait for its transfer
    task automatic send_instr(input instr_t ins, input int max_gap);
        int gap;
        gap = (max_gap == 0) ? 0 : int'($unsigned($random(seed)) % (max_gap + 1));
        repeat (gap) begin
            @(posedge clk);
        end
        instr_valid_i <= 1'b1;
        instr_i       <= ins;
        @(posedge clk);
        while (!instr_ready_o) begin
            @(posedge clk);
        end
        instr_valid_i <= 1'b0;
        recent[2] = recent[1];
        recent[1] = recent[0];
        recent[0] = ins[11:7];
    endtask

    task automatic run_alu_chains(input int n);
        reg_idx_t s1;
        reg_idx_t s2;
        for (int i = 0; i < n; i++) begin
            s1 = pick_src();
            s2 = pick_src();
            send_instr(rand_alu(pick_dst(), s1, s2), 2);
        end
    endtask

    task automatic run_load_use(input int n);
        reg_idx_t ld_rd;
        reg_idx_t base;
        reg_idx_t other;
        for (int i = 0; i < n; i++) begin
            ld_rd = pick_dst();
            base  = pick_src();
            other = pick_src();
            send_instr(enc_i(12'($random(seed)), base, 3'b011, ld_rd, OPC_LOAD), 2);
            if (i % 2 == 0) begin
                send_instr(enc_r(7'h00, other, ld_rd, 3'b000, pick_dst()), 0);  // user on rs1
            end else begin
                send_instr(enc_r(7'h20, ld_rd, other, 3'b000, pick_dst()), 0);  // user on rs2
            end
        end
    endtask

    task automatic run_x0_unknown(input int n);
        for (int i = 0; i < n; i++) begin
            case (i % 4)
                0: send_instr(enc_i(12'($random(seed)), pick_src(), 3'b000, '0, OPC_OP_IMM), 1);
                1: send_instr({25'($random(seed)), 7'h7f}, 1);      // no such opcode
                2: send_instr(enc_i(12'($random(seed)), pick_src(), 3'b011, '0, OPC_LOAD), 1);
                default: begin
                    if (i % 8 == 3) begin
                        send_instr(enc_r(7'h00, '0, '0, 3'b110, pick_dst()), 0);
                    end else begin
                        send_instr(enc_r(7'h00, '0, pick_src(), 3'b000, pick_dst()), 0);
                    end
                end
            endcase
        end
    endtask

    task automatic run_random_mix(input int n);
        reg_idx_t rd;
        reg_idx_t s1;
        reg_idx_t s2;
        int       k;
        for (int i = 0; i < n; i++) begin
            rd = reg_idx_t'($unsigned($random(seed)) % 8);       // x0 now and then
            s1 = pick_src();
            s2 = pick_src();
            k  = int'($unsigned($random(seed)) % 10);
            if (k < 7) begin
                send_instr(rand_alu(rd, s1, s2), 2);
            end else if (k < 9) begin
                send_instr(enc_i(12'($random(seed)), s1, 3'b011, rd, OPC_LOAD), 2);
            end else begin
                send_instr({25'($random(seed)), 7'h7f}, 2);
            end
        end
    endtask

    // drain the pipe and report one test
    task automatic close_test(input string name, input int e0, input int a0);
        @(posedge clk);
        while (rd_idx != wr_idx) begin
            @(posedge clk);
        end
        n_tests++;
        $display("test %s done: %0d instructions, %0d errors", name, wr_idx - a0, err_cnt - e0);
    endtask

    initial begin
        int e0;
        int a0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        model_pc      = `RV_RESET_PC;
        for (int i = 0; i < `RV_REG_NUM; i++) begin
            ref_regs[i] = '0;
        end
        recent[0] = 5'd1;
        recent[1] = 5'd2;
        recent[2] = 5'd3;
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;

        e0 = err_cnt;
        a0 = wr_idx;
        repeat (3 + $unsigned($random(seed)) % 6) @(posedge clk);     // idle, nothing offered
        close_test("reset_idle", e0, a0);

        e0 = err_cnt;
        a0 = wr_idx;
        run_alu_chains(N_ALU);
        close_test("alu_chains", e0, a0);

        e0 = err_cnt;
        a0 = wr_idx;
        run_load_use(N_LOAD_USE);
        close_test("load_use", e0, a0);

        e0 = err_cnt;
        a0 = wr_idx;
        run_x0_unknown(N_X0);
        close_test("x0_unknown", e0, a0);

        e0 = err_cnt;
        a0 = wr_idx;
        run_random_mix(N_MIX);
        close_test("random_mix", e0, a0);

        repeat (10) @(posedge clk);
        if (rd_idx != wr_idx) begin
            report_failure("accepted and committed instruction counts differ");
        end
        $display("summary: %0d tests, %0d accepted, %0d committed, %0d errors",
                 n_tests, wr_idx, rd_idx, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
